// File: files.f
logic/mem_pkg.sv
logic/cpu_cache.sv
logic/cpu_cache_ctrl.sv
logic/mem_system.sv
tb/mem_system_assertions.sv
tb/tb_mem_system.sv

// File: run.sh
#!/bin/sh
# Compile the memory subsystem testbench with Verilator, run it, and look for the pass line

verilator --binary --assert --timing -f files.f --top-module tb_mem_system -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -F -q -- '*** PASSED ***' \
	&& echo "simulation run ok" \
	|| { echo "simulation run failed"; exit 1; }

// File: tb/tb_mem_system.sv
/*
 * Testbench for mem_system: drives core requests, models the host memory agent,
 * and checks read data and hit status against a shadow memory and tag table.
 */
`default_nettype none

module tb_mem_system
	import mem_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int INDEX_W = 4;
	localparam int NUM_REQUESTS = 413;
	localparam int CYCLE_LIMIT = NUM_REQUESTS * 25 + 200;

	logic clk = 1'b0;
	logic reset;
	logic en;
	logic wr;
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] data_in;
	logic [WORD_W-1:0] data_out;
	logic data_valid;
	logic done;
	logic cache_hit;
	logic [LINE_W-1:0] data_in_host = '0;
	logic tx_done_host = 1'b0;
	logic rd_valid_host = 1'b0;
	logic [LINE_W-1:0] data_out_host;
	logic [ADDR_W-1:0] addr_out_host;
	host_op_t op_host;

	// Shadow state for the reference model
	logic [31:0] shadow_mem [logic [29:0]];
	logic sv_valid [16];
	logic [21:0] sv_tag [16];
	logic sv_dirty [16];

	// Host agent memory and what it saw
	logic [LINE_W-1:0] host_mem [logic [25:0]];
	host_op_t host_log [$];
	logic [31:0] wb_addr;
	logic [LINE_W-1:0] wb_line;
	int wait_left = 0;

	// Outstanding expectations, oldest first
	string exp_name [$];
	logic exp_wr [$];
	logic [31:0] exp_data [$];
	logic exp_hit [$];
	string cur_name;
	logic cur_wr;
	logic [31:0] cur_data;
	logic cur_hit;

	logic [31:0] stim_lfsr = 32'h8aaa;
	logic [31:0] resp_lfsr = 32'h8aaa;
	int cycle = 0;
	int accept_cycle = 0;
	int last_latency = 0;
	int sent = 0;
	int received = 0;
	int valid_pulses = 0;
	int checks = 0;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;

	mem_system #(
		.INDEX_W(INDEX_W)
	) dut (
		.clk           (clk),
		.reset         (reset),
		.en            (en),
		.wr            (wr),
		.addr          (addr),
		.data_in       (data_in),
		.data_out      (data_out),
		.data_valid    (data_valid),
		.done          (done),
		.cache_hit     (cache_hit),
		.data_in_host  (data_in_host),
		.tx_done_host  (tx_done_host),
		.rd_valid_host (rd_valid_host),
		.data_out_host (data_out_host),
		.addr_out_host (addr_out_host),
		.op_host       (op_host)
	);

	always #10 clk = ~clk;

	// Galois LFSR, one step per bit handed out
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
			v = {v[30:0], state[0]};
		end
		return v;
	endfunction

	// Memory contents before anything is written
	function automatic logic [31:0] init_word(input logic [31:0] a);
		return {2'b00, a[31:2]} ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [LINE_W-1:0] fetch_line(input logic [31:0] a);
		logic [LINE_W-1:0] l;
		int w;
		if (host_mem.exists(a[31:6])) begin
			return host_mem[a[31:6]];
		end
		for (w = 0; w < 16; w++) begin
			l[w*32 +: 32] = init_word({a[31:6], w[3:0], 2'b00});
		end
		return l;
	endfunction

	// Expected {hit, read word} for a request at a
	function automatic logic [32:0] reference(input logic [31:0] a);
		logic [3:0] s;
		logic hit_p;
		logic [31:0] word;
		s = a[9:6];
		hit_p = sv_valid[s] && (sv_tag[s] == a[31:10]);
		word = shadow_mem.exists(a[31:2]) ? shadow_mem[a[31:2]] : init_word(a);
		return {hit_p, word};
	endfunction

	// A miss at a must first write back a dirty resident line
	function automatic logic expect_writeback(input logic [31:0] a);
		logic [3:0] s;
		s = a[9:6];
		return sv_valid[s] && sv_dirty[s] && (sv_tag[s] != a[31:10]);
	endfunction

	task automatic update_model(input logic w, input logic [31:0] a, input logic [31:0] d);
		logic [3:0] s;
		s = a[9:6];
		if (w) begin
			shadow_mem[a[31:2]] = d;
		end
		if (sv_valid[s] && (sv_tag[s] == a[31:10])) begin
			sv_dirty[s] = sv_dirty[s] | w;
		end else begin
			sv_valid[s] = 1'b1;
			sv_tag[s] = a[31:10];
			sv_dirty[s] = w;
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic send(input string name, input logic w, input logic [31:0] a,
			input logic [31:0] d);
		logic [32:0] ref_val;
		@(negedge clk);
		while (!done) begin
			@(negedge clk);
		end
		ref_val = reference(a);
		exp_name.push_back(name);
		exp_wr.push_back(w);
		exp_data.push_back(ref_val[31:0]);
		exp_hit.push_back(ref_val[32]);
		update_model(w, a, d);
		en = 1'b1;
		wr = w;
		addr = a;
		data_in = d;
		accept_cycle = cycle + 1;
		sent++;
		@(negedge clk);
		en = 1'b0;
	endtask

	task automatic wait_response();
		while (received != sent) begin
			@(negedge clk);
		end
	endtask

	task automatic request(input string name, input logic w, input logic [31:0] a,
			input logic [31:0] d);
		logic wb_exp;
		int writes;
		wb_exp = expect_writeback(a);
		host_log.delete();
		send(name, w, a, d);
		wait_response();
		writes = 0;
		foreach (host_log[i]) begin
			if (host_log[i] == HOST_WRITE) begin
				writes++;
			end
		end
		check({name, " writebacks"}, {31'd0, wb_exp}, 32'(writes));
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// Host agent, answers each op after 1 to 8 cycles
	always @(negedge clk) begin
		tx_done_host = 1'b0;
		rd_valid_host = 1'b0;
		if (!reset && (op_host == HOST_WRITE || op_host == HOST_READ)) begin
			if (wait_left == 0) begin
				wait_left = int'(take_bits(resp_lfsr, 3)) + 1;
			end
			wait_left = wait_left - 1;
			if (wait_left == 0) begin
				host_log.push_back(op_host);
				if (op_host == HOST_WRITE) begin
					host_mem[addr_out_host[31:6]] = data_out_host;
					wb_addr = addr_out_host;
					wb_line = data_out_host;
					tx_done_host = 1'b1;
				end else begin
					data_in_host = fetch_line(addr_out_host);
					rd_valid_host = 1'b1;
				end
			end
		end
	end

	// Response checker
	always @(negedge clk) begin
		if (data_valid) begin
			valid_pulses++;
			if (exp_name.size() == 0) begin
				errors++;
				$display("Unexpected data_valid with no request outstanding");
			end else begin
				cur_name = exp_name.pop_front();
				cur_wr = exp_wr.pop_front();
				cur_data = exp_data.pop_front();
				cur_hit = exp_hit.pop_front();
				if (!cur_wr) begin
					check({cur_name, " data"}, cur_data, data_out);
				end
				check({cur_name, " hit"}, {31'd0, cur_hit}, {31'd0, cache_hit});
				last_latency = cycle - accept_cycle;
				received++;
			end
		end
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > CYCLE_LIMIT) begin
			$display("Timeout: the DUT stopped answering after %0d cycles", cycle);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		logic [31:0] bits;
		logic [31:0] rnd_addr;
		int n;
		reset = 1'b1;
		en = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		for (n = 0; n < 16; n++) begin
			sv_valid[n] = 1'b0;
			sv_tag[n] = '0;
			sv_dirty[n] = 1'b0;
		end
		repeat (4) @(negedge clk);
		reset = 1'b0;

		check("reset done", 32'd1, {31'd0, done});
		check("reset op_host", 32'(HOST_NONE), 32'(op_host));
		check("reset data_valid", 32'd0, {31'd0, data_valid});
		request("first_miss", 1'b0, 32'h0001_0040, 32'd0);
		finish_test("reset_first_miss");

		request("read_hit", 1'b0, 32'h0001_0040, 32'd0);
		check("read_hit latency", 32'd2, 32'(last_latency));
		finish_test("read_hit");

		request("write_hit", 1'b1, 32'h0001_0040, 32'hdead_beef);
		request("read_back", 1'b0, 32'h0001_0040, 32'd0);
		request("write_alloc", 1'b1, 32'h0001_0088, 32'h1234_5678);
		request("alloc_word", 1'b0, 32'h0001_0088, 32'd0);
		request("alloc_low", 1'b0, 32'h0001_0080, 32'd0);
		request("alloc_high", 1'b0, 32'h0001_00bc, 32'd0);
		finish_test("write_hit_alloc");

		// Dirty victim goes out before the fill
		host_log.delete();
		request("evict_dirty", 1'b0, 32'h0001_0440, 32'd0);
		check("evict_dirty ops", 32'd2, 32'(host_log.size()));
		if (host_log.size() == 2) begin
			check("evict_dirty first op", 32'(HOST_WRITE), 32'(host_log[0]));
			check("evict_dirty second op", 32'(HOST_READ), 32'(host_log[1]));
		end
		check("evict_dirty wb addr", 32'h0001_0040, wb_addr);
		check("evict_dirty wb word", 32'hdead_beef, wb_line[31:0]);
		host_log.delete();
		request("evict_clean", 1'b0, 32'h0001_0840, 32'd0);
		check("evict_clean ops", 32'd1, 32'(host_log.size()));
		if (host_log.size() == 1) begin
			check("evict_clean op", 32'(HOST_READ), 32'(host_log[0]));
		end
		request("refetch", 1'b0, 32'h0001_0040, 32'd0);
		finish_test("evict");

		for (n = 0; n < 400; n++) begin
			bits = take_bits(stim_lfsr, 9);
			rnd_addr = {16'h0001, 4'h0, bits[7:6], 2'b00, bits[5:4], bits[3:0], 2'b00};
			request("random", bits[8], rnd_addr, take_bits(stim_lfsr, 32));
		end
		finish_test("random");

		// Requests while busy must be dropped
		send("busy_miss", 1'b0, 32'h0002_0000, 32'd0);
		while (!done) begin
			en = 1'b1;
			wr = 1'b1;
			addr = 32'h0002_0004;
			data_in = 32'hbad0_bad0;
			@(negedge clk);
		end
		en = 1'b0;
		wait_response();
		repeat (10) @(negedge clk);
		check("busy responses", 32'(sent), 32'(valid_pulses));
		request("busy_untouched", 1'b0, 32'h0002_0004, 32'd0);
		finish_test("busy_ignore");

		errors = errors + dut.protocol_checks.fail_count;
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/mem_system_assertions.sv
/*
 * Core and host port protocol checks, bound into every mem_system instance.
 */
`default_nettype none

module mem_system_assertions
	import mem_pkg::*;
(
	input wire logic     clk,
	input wire logic     reset,
	input wire logic     done,
	input wire logic     data_valid,
	input wire logic     tx_done_host,
	input wire logic     rd_valid_host,
	input wire host_op_t op_host
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// Host op is held until the agent answers it
	op_stable: assert property (@(posedge clk) disable iff (reset)
		(op_host != HOST_NONE && !tx_done_host && !rd_valid_host) |=> op_host == $past(op_host))
		else begin
			$error("op_host changed before its answer");
			fail_count++;
		end

	// A response only ends a busy period
	valid_after_busy: assert property (@(posedge clk) disable iff (reset)
		data_valid |-> !$past(done))
		else begin
			$error("data_valid while done was high in the previous cycle");
			fail_count++;
		end

	done_with_valid: assert property (@(posedge clk) disable iff (reset)
		(done && !$past(done)) |-> data_valid)
		else begin
			$error("done rose without data_valid");
			fail_count++;
		end

endmodule

bind mem_system mem_system_assertions protocol_checks (
	.clk           (clk),
	.reset         (reset),
	.done          (done),
	.data_valid    (data_valid),
	.tx_done_host  (tx_done_host),
	.rd_valid_host (rd_valid_host),
	.op_host       (op_host)
);

`default_nettype wire

// File: logic/mem_system.sv
/*
 * Memory subsystem top level: a direct-mapped write-back cache and its
 * controller, between a core's word port and a line-wide host port.
 */
`default_nettype none

module mem_system
	import mem_pkg::*;
#(
	parameter int INDEX_W = 8
) (
	input  wire logic               clk,
	input  wire logic               reset,

	// Core port
	input  wire logic               en,
	input  wire logic               wr,
	input  wire logic [ADDR_W-1:0]  addr,
	input  wire logic [WORD_W-1:0]  data_in,
	output logic [WORD_W-1:0]       data_out,
	output logic                    data_valid,
	output logic                    done,
	output logic                    cache_hit,

	// Host port to the DMA/memory agent
	input  wire logic [LINE_W-1:0]  data_in_host,
	input  wire logic               tx_done_host,
	input  wire logic               rd_valid_host,
	output logic [LINE_W-1:0]       data_out_host,
	output logic [ADDR_W-1:0]       addr_out_host,
	output host_op_t                op_host
);

	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	// Controller to cache
	logic [INDEX_W-1:0]    index;
	logic [TAG_W-1:0]      tag;
	logic [WORD_SEL_W-1:0] word_sel;
	logic                  word_wr;
	logic [WORD_W-1:0]     word_data;
	logic                  line_wr;
	logic [LINE_W-1:0]     line_data;

	// Cache back to controller
	logic                  hit;
	logic                  dirty;
	logic [TAG_W-1:0]      victim_tag;
	logic [WORD_W-1:0]     rd_word;
	logic [LINE_W-1:0]     rd_line;

	cpu_cache_ctrl #(
		.INDEX_W(INDEX_W)
	) cache_ctrl (
		.clk           (clk),
		.reset         (reset),
		.en            (en),
		.wr            (wr),
		.addr          (addr),
		.data_in       (data_in),
		.data_out      (data_out),
		.data_valid    (data_valid),
		.done          (done),
		.cache_hit     (cache_hit),
		.data_in_host  (data_in_host),
		.tx_done_host  (tx_done_host),
		.rd_valid_host (rd_valid_host),
		.data_out_host (data_out_host),
		.addr_out_host (addr_out_host),
		.op_host       (op_host),
		.hit           (hit),
		.dirty         (dirty),
		.victim_tag    (victim_tag),
		.rd_word       (rd_word),
		.rd_line       (rd_line),
		.index         (index),
		.tag           (tag),
		.word_sel      (word_sel),
		.word_wr       (word_wr),
		.word_data     (word_data),
		.line_wr       (line_wr),
		.line_data     (line_data)
	);

	cpu_cache #(
		.INDEX_W(INDEX_W)
	) c0 (
		.clk        (clk),
		.reset      (reset),
		.index      (index),
		.tag        (tag),
		.word_sel   (word_sel),
		.word_wr    (word_wr),
		.word_data  (word_data),
		.line_wr    (line_wr),
		.line_data  (line_data),
		.hit        (hit),
		.dirty      (dirty),
		.victim_tag (victim_tag),
		.rd_word    (rd_word),
		.rd_line    (rd_line)
	);

endmodule

`default_nettype wire

// File: logic/cpu_cache_ctrl.sv
/*
 * Cache controller: accepts one core word request at a time, looks it up,
 * writes back a dirty victim, fetches the missing line over the host port
 * and answers the core with data_valid and a hit/miss status.
 */
`default_nettype none

module cpu_cache_ctrl
	import mem_pkg::*;
#(
	parameter int INDEX_W = 8
) (
	input  wire logic                          clk,
	input  wire logic                          reset,

	// Core request
	input  wire logic                          en,
	input  wire logic                          wr,
	input  wire logic [ADDR_W-1:0]             addr,
	input  wire logic [WORD_W-1:0]             data_in,

	// Core response
	output logic [WORD_W-1:0]                  data_out,
	output logic                               data_valid,
	output logic                               done,
	output logic                               cache_hit,

	// Host agent answers
	input  wire logic [LINE_W-1:0]             data_in_host,
	input  wire logic                          tx_done_host,
	input  wire logic                          rd_valid_host,

	// Host requests
	output logic [LINE_W-1:0]                  data_out_host,
	output logic [ADDR_W-1:0]                  addr_out_host,
	output host_op_t                           op_host,

	// Cache lookup results
	input  wire logic                          hit,
	input  wire logic                          dirty,
	input  wire logic [ADDR_W-INDEX_W-OFFSET_W-1:0] victim_tag,
	input  wire logic [WORD_W-1:0]             rd_word,
	input  wire logic [LINE_W-1:0]             rd_line,

	// Cache address and writes
	output logic [INDEX_W-1:0]                 index,
	output logic [ADDR_W-INDEX_W-OFFSET_W-1:0] tag,
	output logic [WORD_SEL_W-1:0]              word_sel,
	output logic                               word_wr,
	output logic [WORD_W-1:0]                  word_data,
	output logic                               line_wr,
	output logic [LINE_W-1:0]                  line_data
);

	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int BYTE_W = OFFSET_W - WORD_SEL_W;

	ctrl_state_t state;

	// Latched request
	logic                  req_wr;
	logic [TAG_W-1:0]      req_tag;
	logic [INDEX_W-1:0]    req_index;
	logic [WORD_SEL_W-1:0] req_word;
	logic [WORD_W-1:0]     req_data;

	// Lookup outcome, reported at response time
	logic hit_r;

	logic accept;
	logic fill_done;
	logic [LINE_W-1:0] merged_line;

	assign done = (state == ST_IDLE);
	assign accept = en && done;

	// Read answer only counts once HOST_READ is actually on the port
	assign fill_done = (state == ST_FILL) && (op_host == HOST_READ) && rd_valid_host;

	// Request latch
	always_ff @(posedge clk) begin
		if (accept) begin
			req_wr <= wr;
			req_tag <= addr[ADDR_W-1 -: TAG_W];
			req_index <= addr[OFFSET_W +: INDEX_W];
			req_word <= addr[BYTE_W +: WORD_SEL_W];
			req_data <= data_in;
		end
	end

	// Cache always sees the latched request
	assign index = req_index;
	assign tag = req_tag;
	assign word_sel = req_word;
	assign word_data = req_data;

	// Write word folded into the incoming line
	always_comb begin
		merged_line = data_in_host;
		if (req_wr) begin
			merged_line[req_word*WORD_W +: WORD_W] = req_data;
		end
	end

	assign line_wr = fill_done;
	assign line_data = merged_line;

	// Word write on a write hit, or alongside the fill to mark it dirty
	assign word_wr = req_wr && (fill_done || ((state == ST_RESPOND) && hit_r));

	// Victim line goes out as read from the cache
	assign data_out_host = rd_line;

	// Victim address during writeback, request line otherwise
	always_comb begin
		if (state == ST_WRITEBACK) begin
			addr_out_host = {victim_tag, req_index, {OFFSET_W{1'b0}}};
		end else begin
			addr_out_host = {req_tag, req_index, {OFFSET_W{1'b0}}};
		end
	end

	// Miss handling FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			op_host <= HOST_NONE;
			hit_r <= 1'b0;
			data_valid <= 1'b0;
			cache_hit <= 1'b0;
		end else begin
			data_valid <= 1'b0;
			cache_hit <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					hit_r <= hit;
					if (hit) begin
						state <= ST_RESPOND;
					end else if (dirty) begin
						state <= ST_WRITEBACK;
						op_host <= HOST_WRITE;
					end else begin
						state <= ST_FILL;
						op_host <= HOST_READ;
					end
				end
				ST_WRITEBACK: begin
					// Port drops to idle for a cycle before the read
					if (tx_done_host) begin
						state <= ST_FILL;
						op_host <= HOST_NONE;
					end
				end
				ST_FILL: begin
					if (op_host == HOST_NONE) begin
						op_host <= HOST_READ;
					end else if (fill_done) begin
						state <= ST_RESPOND;
						op_host <= HOST_NONE;
					end
				end
				ST_RESPOND: begin
					data_valid <= 1'b1;
					cache_hit <= hit_r;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
					op_host <= HOST_NONE;
				end
			endcase
		end
	end

	// Read word after any fill has landed
	always_ff @(posedge clk) begin
		if (state == ST_RESPOND) begin
			data_out <= rd_word;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_cache.sv
/*
 * Direct-mapped cache storage: one tag, valid bit, dirty bit and line per set.
 * Lookup is combinational on index and tag; writes take a word or a whole line.
 */
`default_nettype none

module cpu_cache
	import mem_pkg::*;
#(
	parameter int INDEX_W = 8
) (
	input  wire logic                          clk,
	input  wire logic                          reset,

	// Lookup address from the controller
	input  wire logic [INDEX_W-1:0]            index,
	input  wire logic [ADDR_W-INDEX_W-OFFSET_W-1:0] tag,
	input  wire logic [WORD_SEL_W-1:0]         word_sel,

	// Word write, marks the line dirty
	input  wire logic                          word_wr,
	input  wire logic [WORD_W-1:0]             word_data,

	// Whole-line install
	input  wire logic                          line_wr,
	input  wire logic [LINE_W-1:0]             line_data,

	// Lookup results
	output logic                               hit,
	output logic                               dirty,
	output logic [ADDR_W-INDEX_W-OFFSET_W-1:0] victim_tag,
	output logic [WORD_W-1:0]                  rd_word,
	output logic [LINE_W-1:0]                  rd_line
);

	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int SETS = 1 << INDEX_W;

	// Payload arrays
	logic [TAG_W-1:0]  tag_mem  [SETS];
	logic [LINE_W-1:0] line_mem [SETS];

	// Per-set status
	logic [SETS-1:0] valid_bits;
	logic [SETS-1:0] dirty_bits;

	// Read side follows index every cycle
	assign victim_tag = tag_mem[index];
	assign rd_line = line_mem[index];
	assign rd_word = rd_line[word_sel*WORD_W +: WORD_W];

	assign hit = valid_bits[index] && (tag_mem[index] == tag);

	// An invalid set never needs a writeback
	assign dirty = valid_bits[index] && dirty_bits[index];

	// Line install wins over a word write on the same edge
	always_ff @(posedge clk) begin
		if (line_wr) begin
			tag_mem[index] <= tag;
			line_mem[index] <= line_data;
		end else if (word_wr) begin
			line_mem[index][word_sel*WORD_W +: WORD_W] <= word_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (line_wr) begin
			valid_bits[index] <= 1'b1;
			// Fill with a merged write word comes in dirty
			dirty_bits[index] <= word_wr;
		end else if (word_wr) begin
			dirty_bits[index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
/*
 * Shared widths and enums for the CPU-side memory subsystem.
 * Imported by the cache, its controller and the top level.
 */
`default_nettype none

package mem_pkg;

	// Core side
	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;

	// Line geometry, 64-byte lines of sixteen words
	localparam int OFFSET_W = 6;
	localparam int WORD_SEL_W = 4;
	localparam int LINE_W = 512;

	// Host port operation, held until the agent answers
	typedef enum logic [1:0] {
		HOST_NONE  = 2'd0,
		HOST_READ  = 2'd1,
		HOST_WRITE = 2'd2
	} host_op_t;

	// Miss-handling FSM of the controller
	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_LOOKUP    = 3'd1,
		ST_WRITEBACK = 3'd2,
		ST_FILL      = 3'd3,
		ST_RESPOND   = 3'd4
	} ctrl_state_t;

endpackage

`default_nettype wire
